// File: all.f
+incdir+.
feat_pkg.sv
pixel_window.sv
kernel_bank.sv
row_serialiser.sv
feat_top.sv
feat_chk.sv
tb_feat_top.sv

// File: Makefile
LOG := sim.log

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -Wno-fatal --top-module tb_feat_top \
		-f all.f -Mdir obj_dir -o sim

run: compile
	./obj_dir/sim | tee $(LOG)
	@if grep -q "ERRORS FOUND" $(LOG); then echo "Simulation failed"; exit 1; fi
	@if ! grep -q "NO ERRORS" $(LOG); then echo "Simulation ended early"; exit 1; fi
	@echo "Simulation passed"

clean:
	rm -rf obj_dir $(LOG)

// File: tb_feat_top.sv
`timescale 1ns/1ps
`include "feat_defs.svh"

module tb_feat_top
    import feat_pkg::*;
();

    localparam int LAST_COL    = `FEAT_ROW_COLS - 1;
    localparam int LAST_LANE   = `FEAT_LANES - 1;
    localparam int TOTAL_ROWS  = 8;
    localparam int CYCLE_LIMIT = TOTAL_ROWS * `FEAT_ROW_COLS * 12 + 200;
    localparam int DRAIN_LIMIT = 40;

    typedef struct packed {
        int res;
        int lane;
        int col;
        bit row_end;
    } exp_beat_t;

    logic                   clk;
    logic                   rst;
    logic                   pix_valid;
    logic [`FEAT_PIX_W-1:0] pix;
    logic                   o_valid;
    out_beat_t              o_beat;

    exp_beat_t   exp_q[$];
    logic [31:0] lcg_state = 32'h5954_2a2e;
    string       test_name = "power_on_reset";
    int          errors;
    int          cycles;
    int          beats_checked;
    int          row_ends_seen;
    int          exp_row_ends;
    int          ref_col;
    int          h0;                     // Oldest pixel of the model window
    int          h1;
    int          h2;
    logic        rst_q = 1'b1;           // Reset as the DUT last sampled it
    logic        prev_valid = 1'b0;
    int          prev_lane;
    logic        tight_spacing = 1'b0;

    feat_top dut_i (
        .clk         (clk),
        .rst         (rst),
        .i_pix_valid (pix_valid),
        .i_pix       (pix),
        .o_valid     (o_valid),
        .o_beat      (o_beat)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    always @(posedge clk) begin
        rst_q  <= rst;
        cycles <= cycles + 1;
        if (cycles >= CYCLE_LIMIT) begin
            $display("Timeout after %0d cycles during %s", cycles, test_name);
            errors++;
            report_and_finish();
        end
    end

    function automatic logic [15:0] next_rand();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state[31:16];
    endfunction

    // Weighted 3-tap sum at full integer precision
    function automatic int kernel_ref(input int lane, input int p0, input int p1, input int p2);
        return int'(feat_kernels[lane].w0) * p0 + int'(feat_kernels[lane].w1) * p1
             + int'(feat_kernels[lane].w2) * p2;
    endfunction

    task automatic model_pixel(input int value);
        exp_beat_t b;
        h0 = h1;
        h1 = h2;
        h2 = value;
        if (ref_col >= 2) begin          // Window lies inside one row
            for (int l = 0; l < `FEAT_LANES; l++) begin
                b.res     = kernel_ref(l, h0, h1, h2);
                b.lane    = l;
                b.col     = ref_col;
                b.row_end = (l == LAST_LANE) && (ref_col == LAST_COL);
                exp_q.push_back(b);
            end
            if (ref_col == LAST_COL) exp_row_ends++;
        end
        ref_col = (ref_col == LAST_COL) ? 0 : ref_col + 1;
    endtask

    task automatic flush_expected();
        foreach (exp_q[i]) begin
            if (exp_q[i].row_end) exp_row_ends--;
        end
        exp_q.delete();
    endtask

    // Entered and left on a rising edge
    task automatic send_pixel(input logic [`FEAT_PIX_W-1:0] value, input int gap);
        pix_valid <= 1'b1;
        pix       <= value;
        model_pixel(value);
        @(posedge clk);
        pix_valid <= 1'b0;
        repeat (gap - 1) @(posedge clk);
    endtask

    task automatic apply_reset(input int n);
        rst <= 1'b1;
        repeat (n) @(posedge clk);
        flush_expected();                // Bursts in flight are dropped
        ref_col = 0;
        rst <= 1'b0;
        @(posedge clk);
    endtask

    task automatic wait_drain();
        int waited;
        waited = 0;
        while (exp_q.size() != 0 && waited < DRAIN_LIMIT) begin
            @(posedge clk);
            waited++;
        end
        assert (exp_q.size() == 0) else begin
            errors++;
            $display("%0d expected beats never appeared in %s", exp_q.size(), test_name);
            flush_expected();
        end
        repeat (4) @(posedge clk);       // Catch stray beats
    endtask

    task automatic check_field(input string what, input int expected, input int actual);
        assert (expected == actual) else begin
            errors++;
            $display("FAIL %s %s: expected %0d actual %0d", test_name, what, expected, actual);
        end
    endtask

    task automatic run_random_rows(input int rows);
        logic [`FEAT_PIX_W-1:0] value;
        int                     gap;
        test_name = "random_rows";
        for (int i = 0; i < rows * `FEAT_ROW_COLS; i++) begin
            value = `FEAT_PIX_W'(next_rand());
            gap   = 8 + int'(next_rand() % 16'd4);
            send_pixel(value, gap);
        end
        wait_drain();
    endtask

    task automatic run_min_spacing();
        test_name     = "min_spacing";
        tight_spacing = 1'b1;
        for (int i = 0; i < `FEAT_ROW_COLS; i++) begin
            send_pixel(`FEAT_PIX_W'(next_rand()), 8);
        end
        wait_drain();
        tight_spacing = 1'b0;
    endtask

    // Runs of 0 and 255, run length 2**shift
    task automatic run_pattern_row(input int shift);
        test_name = "extremes";
        for (int i = 0; i < `FEAT_ROW_COLS; i++) begin
            send_pixel(((i >> shift) & 1) ? 8'hFF : 8'h00, 8);
        end
        wait_drain();
    endtask

    task automatic run_reset_mid_row();
        test_name = "reset_mid_row";
        for (int i = 0; i < 7; i++) begin
            send_pixel(`FEAT_PIX_W'(next_rand()), 9);
        end
        send_pixel(`FEAT_PIX_W'(next_rand()), 5);   // Reset lands inside this burst
        apply_reset(4);
        for (int i = 0; i < `FEAT_ROW_COLS; i++) begin
            send_pixel(`FEAT_PIX_W'(next_rand()), 8);
        end
        wait_drain();
    endtask

    task automatic report_and_finish();
        $display("Checked %0d beats, %0d row ends, %0d errors",
                 beats_checked, row_ends_seen, errors);
        if (errors == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    endtask

    // Outputs settle after the rising edge, so compare on the falling one
    always @(negedge clk) begin
        exp_beat_t want;
        if (rst_q) begin
            assert (!o_valid) else begin
                errors++;
                $display("Output beat while reset was applied");
            end
            prev_valid = 1'b0;
        end else if (o_valid) begin
            assert (exp_q.size() != 0) else begin
                errors++;
                $display("Beat for lane %0d col %0d arrived with nothing expected",
                         o_beat.lane, o_beat.col);
            end
            if (exp_q.size() != 0) begin
                want = exp_q.pop_front();
                check_field("res", want.res, $signed(o_beat.res));
                check_field("lane", want.lane, o_beat.lane);
                check_field("col", want.col, o_beat.col);
                check_field("row_end", want.row_end, o_beat.row_end);
                beats_checked++;
            end
            assert (o_beat.col >= 2) else begin
                errors++;
                $display("Beat for column %0d, which has no full window", o_beat.col);
            end
            assert (o_beat.lane == 0 || (prev_valid && prev_lane == int'(o_beat.lane) - 1))
            else begin
                errors++;
                $display("Lane %0d did not follow the previous lane", o_beat.lane);
            end
            if (o_beat.row_end) row_ends_seen++;
            prev_valid = 1'b1;
            prev_lane  = int'(o_beat.lane);
        end else begin
            assert (!prev_valid || prev_lane == LAST_LANE) else begin
                errors++;
                $display("Burst stopped after lane %0d", prev_lane);
            end
            assert (!(tight_spacing && prev_valid && exp_q.size() != 0)) else begin
                errors++;
                $display("Idle cycle between bursts at minimum pixel spacing");
            end
            prev_valid = 1'b0;
        end
    end

    initial begin
        rst       = 1'b1;
        pix_valid = 1'b0;
        pix       = '0;
        repeat (8) @(posedge clk);
        rst <= 1'b0;
        @(posedge clk);
        run_random_rows(3);
        run_min_spacing();
        run_pattern_row(0);
        run_pattern_row(1);
        run_reset_mid_row();
        assert (row_ends_seen == exp_row_ends) else begin
            errors++;
            $display("Saw %0d row ends for %0d completed rows", row_ends_seen, exp_row_ends);
        end
        report_and_finish();
    end

endmodule

// File: feat_chk.sv
`timescale 1ns/1ps
`include "feat_defs.svh"

module feat_chk
    import feat_pkg::*;
(
    input logic       clk,
    input logic       rst,
    input logic       i_done,
    input logic       o_valid,
    input out_beat_t  o_beat,
    input ser_state_t state_q,
    input lane_t      sel_q
);

    localparam lane_t LAST_LANE = lane_t'(`FEAT_LANES - 1);

    lane_steps: assert property (@(posedge clk) disable iff (rst)
        (state_q == ST_ACT && sel_q != LAST_LANE)
        |=> (state_q == ST_ACT && sel_q == $past(sel_q) + 1'b1))
        else $error("Lane select did not advance by one inside a burst");

    // Pixel source must keep at least 8 cycles between strobes
    done_spacing: assert property (@(posedge clk) disable iff (rst)
        (state_q == ST_ACT && sel_q != LAST_LANE) |-> !i_done)
        else $error("Kernel done arrived before the burst reached lane 7");

    reset_quiet: assert property (@(posedge clk)
        ($past(rst) || $past(rst, 2)) |-> !o_valid)
        else $error("Output valid during or just after reset");

    row_end_lane: assert property (@(posedge clk)
        o_beat.row_end |-> (o_valid && o_beat.lane == LAST_LANE))
        else $error("Row end flagged outside a valid lane 7 beat");

endmodule

bind row_serialiser feat_chk chk_i (
    .clk     (clk),
    .rst     (rst),
    .i_done  (i_done),
    .o_valid (o_valid),
    .o_beat  (o_beat),
    .state_q (state_q),
    .sel_q   (sel_q)
);

// File: feat_top.sv
`timescale 1ns/1ps
`include "feat_defs.svh"

module feat_top
    import feat_pkg::*;
(
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   i_pix_valid,
    input  logic [`FEAT_PIX_W-1:0] i_pix,
    output logic                   o_valid,
    output out_beat_t              o_beat
);

    logic          win_valid;
    pix_window_t   win;
    logic          kb_done;
    lane_results_t kb_res;

    pixel_window win_i (
        .clk         (clk),
        .rst         (rst),
        .i_pix_valid (i_pix_valid),
        .i_pix       (i_pix),
        .o_win_valid (win_valid),
        .o_win       (win)
    );

    kernel_bank kb_i (
        .clk         (clk),
        .rst         (rst),
        .i_win_valid (win_valid),
        .i_win       (win),
        .o_done      (kb_done),
        .o_res       (kb_res)
    );

    row_serialiser ser_i (
        .clk     (clk),
        .rst     (rst),
        .i_done  (kb_done),
        .i_res   (kb_res),
        .o_valid (o_valid),
        .o_beat  (o_beat)
    );

endmodule

// File: row_serialiser.sv
`timescale 1ns/1ps
`include "feat_defs.svh"

module row_serialiser
    import feat_pkg::*;
(
    input  logic          clk,
    input  logic          rst,
    input  logic          i_done,
    input  lane_results_t i_res,
    output logic          o_valid,
    output out_beat_t     o_beat
);

    localparam lane_t LAST_LANE = lane_t'(`FEAT_LANES - 1);

    ser_state_t state_q;
    ser_state_t state_d;
    lane_t      sel_q;                   // Lane currently on the output
    lane_t      sel_d;
    res_t       res_q;
    col_t       col_q;
    logic       row_end_q;

    always_comb begin
        state_d = state_q;
        sel_d   = sel_q;
        case (state_q)
            ST_IDLE: begin
                if (i_done) begin
                    state_d = ST_ACT;
                    sel_d   = '0;
                end
            end
            ST_ACT: begin
                if (sel_q != LAST_LANE) begin
                    sel_d = sel_q + 1'b1;
                end else if (i_done) begin
                    sel_d = '0;          // Back-to-back burst
                end else begin
                    state_d = ST_IDLE;
                end
            end
            default: state_d = ST_IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state_q   <= ST_IDLE;
            sel_q     <= '0;
            row_end_q <= 1'b0;
        end else begin
            state_q   <= state_d;
            sel_q     <= sel_d;
            row_end_q <= (state_d == ST_ACT) && i_res.last && (sel_d == LAST_LANE);
        end
    end

    // Result and column of the selected lane
    always_ff @(posedge clk) begin
        if (state_d == ST_ACT) begin
            res_q <= i_res.res[sel_d];
            col_q <= i_res.col;
        end
    end

    assign o_valid = (state_q == ST_ACT);

    always_comb begin
        o_beat.res     = res_q;
        o_beat.lane    = sel_q;
        o_beat.col     = col_q;
        o_beat.row_end = row_end_q;
    end

endmodule

// File: kernel_bank.sv
`timescale 1ns/1ps
`include "feat_defs.svh"

module kernel_bank
    import feat_pkg::*;
(
    input  logic          clk,
    input  logic          rst,
    input  logic          i_win_valid,
    input  pix_window_t   i_win,
    output logic          o_done,
    output lane_results_t o_res
);

    lane_results_t res_d;

    // Signed 3-tap sum, pixels zero-extended
    function automatic res_t tap_sum(input kernel_t k, input pix_window_t w);
        res_t a0;
        res_t a1;
        res_t a2;
        a0 = w.p0;
        a1 = w.p1;
        a2 = w.p2;
        return k.w0 * a0 + k.w1 * a1 + k.w2 * a2;
    endfunction

    always_comb begin
        for (int l = 0; l < `FEAT_LANES; l++) begin
            res_d.res[l] = tap_sum(feat_kernels[l], i_win);
        end
        res_d.col  = i_win.col;
        res_d.last = i_win.last;
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            o_done <= 1'b0;
        end else begin
            o_done <= i_win_valid;       // One pulse per window
        end
    end

    // Held until the next window strobe
    always_ff @(posedge clk) begin
        if (i_win_valid) begin
            o_res <= res_d;
        end
    end

endmodule

// File: pixel_window.sv
`timescale 1ns/1ps
`include "feat_defs.svh"

module pixel_window
    import feat_pkg::*;
(
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   i_pix_valid,
    input  logic [`FEAT_PIX_W-1:0] i_pix,
    output logic                   o_win_valid,
    output pix_window_t            o_win
);

    localparam col_t LAST_COL = col_t'(`FEAT_ROW_COLS - 1);
    localparam col_t FIRST_WIN_COL = col_t'(2);

    col_t        col_q;                  // Column the next pixel lands in
    logic        row_start;
    logic        col_last;
    logic        win_ok;
    logic        win_valid_q;
    pix_window_t win_q;

    assign row_start = (col_q == '0);
    assign col_last  = (col_q == LAST_COL);
    assign win_ok    = (col_q >= FIRST_WIN_COL);   // Full window inside the row

    // Column counter, wraps at row end
    always_ff @(posedge clk) begin
        if (rst) begin
            col_q <= '0;
        end else if (i_pix_valid) begin
            col_q <= col_last ? '0 : col_q + 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            win_valid_q <= 1'b0;
        end else begin
            win_valid_q <= i_pix_valid && win_ok;
        end
    end

    // Three-pixel history; a new row starts from a clean window
    always_ff @(posedge clk) begin
        if (i_pix_valid) begin
            win_q.col  <= col_q;
            win_q.last <= col_last;
            win_q.p0   <= row_start ? '0 : win_q.p1;
            win_q.p1   <= row_start ? '0 : win_q.p2;
            win_q.p2   <= i_pix;
        end
    end

    assign o_win_valid = win_valid_q;
    assign o_win       = win_q;

endmodule

// File: feat_pkg.sv
`include "feat_defs.svh"

package feat_pkg;

    typedef logic        [`FEAT_PIX_W-1:0]         pix_t;
    typedef logic        [`FEAT_COL_W-1:0]         col_t;
    typedef logic        [$clog2(`FEAT_LANES)-1:0] lane_t;
    typedef logic signed [`FEAT_RES_W-1:0]         res_t;
    typedef logic signed [3:0]                     weight_t;   // Range -4 .. 4

    typedef enum logic {
        ST_IDLE,
        ST_ACT
    } ser_state_t;

    typedef struct packed {
        col_t col;                       // Column of p2
        logic last;
        pix_t p0;                        // Oldest
        pix_t p1;
        pix_t p2;                        // Newest
    } pix_window_t;

    typedef struct packed {
        res_t [`FEAT_LANES-1:0] res;
        col_t                   col;
        logic                   last;
    } lane_results_t;

    typedef struct packed {
        res_t  res;
        lane_t lane;
        col_t  col;
        logic  row_end;
    } out_beat_t;

    // Weights applied to p0, p1, p2
    typedef struct packed {
        weight_t w0;
        weight_t w1;
        weight_t w2;
    } kernel_t;

    localparam kernel_t feat_kernels [`FEAT_LANES] = '{
        '{ 4'sd0,  4'sd1,  4'sd0},       // Pass-through
        '{ 4'sd1,  4'sd1,  4'sd1},       // Box
        '{-4'sd1,  4'sd0,  4'sd1},       // Gradient
        '{ 4'sd1, -4'sd2,  4'sd1},       // Laplacian
        '{ 4'sd1,  4'sd2,  4'sd1},       // Smooth
        '{ 4'sd4,  4'sd0, -4'sd4},
        '{ 4'sd0, -4'sd3,  4'sd3},
        '{-4'sd4,  4'sd4, -4'sd4}
    };

endpackage

// File: feat_defs.svh
`ifndef FEAT_DEFS_SVH
`define FEAT_DEFS_SVH

// Row geometry
`define FEAT_ROW_COLS 16
`define FEAT_COL_W    4          // Index of 0 .. FEAT_ROW_COLS-1

// Parallel kernel lanes
`define FEAT_LANES    8

// Unsigned pixel in
`define FEAT_PIX_W    8

// Signed kernel result out
`define FEAT_RES_W    13         // Holds +/-3060

`endif
